// ==== all.f ====
+incdir+.
rv32_isa_pkg.sv
rv32_front_pkg.sv
rv32_fetch_seq.sv
rv32_pc_gen.sv
rv32_branch_predict.sv
rv32_fetch_out.sv
rv32_front_top.sv
tb_rv32_front.sv

// ==== tb_rv32_front.sv ====
`timescale 1ns/1ps

`include "rv32_front_cfg.svh"

module tb_rv32_front
    import rv32_isa_pkg::*;
    import rv32_front_pkg::*;
();
    localparam int NUM_PROG    = 11;
    localparam int NUM_STEPS   = 12;
    localparam int CYCLE_LIMIT = 20 * NUM_STEPS;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] word;
        logic        fault;
    } prog_entry_t;

    typedef struct packed {
        logic [3:0] stall_cycles;
        logic       flush;
        redirect_t  redirect;
        logic [3:0] packets;
    } step_t;

    logic          clk;
    logic          reset;
    logic          stall;
    logic          flush;
    redirect_t     redirect;
    logic          imem_req;
    imem_req_t     imem_addr;
    logic          imem_ack;
    imem_resp_t    imem_resp;
    fetch_packet_t packet;

    prog_entry_t prog [NUM_PROG];
    step_t       steps [NUM_STEPS];
    logic [31:0] model_pc;
    logic [31:0] lcg_state;
    logic        stall_at_load;
    int          seen_packets;
    int          cycle_count;
    int          packet_errors;
    int          addr_errors;
    int          ctrl_errors;

    rv32_front_top u_rv32_front_top (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .redirect  (redirect),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_resp (imem_resp),
        .packet    (packet)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Addresses outside the program read back as an addi x0 whose
    // immediate is a hash of the full address.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [11:0] imm;
        imm = addr[31:20] ^ addr[19:8] ^ {addr[7:0], addr[31:28]};
        return {imm, 13'd0, 7'b0010011};
    endfunction

    task automatic lookup_program(input logic [31:0] addr, output logic [31:0] word,
                                  output logic is_fault);
        int i;
        word     = fill_word(addr);
        is_fault = 1'b0;
        for (i = 0; i < NUM_PROG; i++) begin
            if (prog[i].addr == addr) begin
                word     = prog[i].word;
                is_fault = prog[i].fault;
            end
        end
    endtask

    function automatic logic takes_branch(input logic [31:0] word);
        return (word[6:0] == OPC_JAL) || ((word[6:0] == OPC_BRANCH) && word[31]);
    endfunction

    function automatic logic [31:0] predicted_next(input logic [31:0] pc,
                                                   input logic [31:0] word);
        logic [31:0] imm_j;
        logic [31:0] imm_b;
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        if (word[6:0] == OPC_JAL) begin
            return pc + imm_j;
        end else if (takes_branch(word)) begin
            return pc + imm_b;
        end else begin
            return pc + 32'd4;
        end
    endfunction

    function automatic fetch_packet_t bubble_packet();
        return '{valid: 1'b0, exception: 1'b0, cause: 4'd0, predicted_taken: 1'b0,
                 pc: 32'd0, instr: `RV32_INSTR_NOP};
    endfunction

    function automatic fetch_packet_t expected_packet(input logic [31:0] pc,
                                                      input logic [31:0] word,
                                                      input logic is_fault);
        fetch_packet_t exp;
        exp.pc              = pc;
        exp.valid           = !is_fault;
        exp.exception       = is_fault;
        exp.cause           = is_fault ? `RV32_MCAUSE_INSTR_FAULT : 4'd0;
        exp.predicted_taken = is_fault ? 1'b0 : takes_branch(word);
        exp.instr           = is_fault ? `RV32_INSTR_NOP : word;
        return exp;
    endfunction

    function automatic step_t make_step(input int stall_cycles, input logic flush_on,
                                        input logic trap, input logic mispredict,
                                        input logic [31:0] trap_pc,
                                        input logic [31:0] branch_pc, input int packets);
        step_t s;
        s.stall_cycles        = stall_cycles[3:0];
        s.flush               = flush_on;
        s.redirect.trap       = trap;
        s.redirect.mispredict = mispredict;
        s.redirect.trap_pc    = trap_pc;
        s.redirect.branch_pc  = branch_pc;
        s.packets             = packets[3:0];
        return s;
    endfunction

    task automatic check_packet(input fetch_packet_t got, input fetch_packet_t exp,
                                input string what);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got v=%0b e=%0b c=%0d t=%0b pc=%08h instr=%08h",
                     $time, what, got.valid, got.exception, got.cause,
                     got.predicted_taken, got.pc, got.instr);
            $display("     expected v=%0b e=%0b c=%0d t=%0b pc=%08h instr=%08h",
                     exp.valid, exp.exception, exp.cause, exp.predicted_taken,
                     exp.pc, exp.instr);
            packet_errors++;
        end
    endtask

    task automatic check_addr(input imem_req_t got, input imem_req_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %08h, expected %08h", $time, what, got.addr, exp.addr);
            addr_errors++;
        end
    endtask

    // A packet is new only if the register was free to load at the last edge.
    task automatic observe_packet();
        logic [31:0]   word;
        logic          is_fault;
        imem_req_t     exp_addr;
        if (!stall_at_load && (packet.valid || packet.exception)) begin
            lookup_program(model_pc, word, is_fault);
            check_packet(packet, expected_packet(model_pc, word, is_fault), "fetched packet");
            model_pc      = predicted_next(model_pc, word);
            exp_addr.addr = model_pc;
            check_addr(imem_addr, exp_addr, "bus address after packet");
            seen_packets++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        observe_packet();
        stall_at_load = stall;
        @(posedge clk);
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("The run timed out after %0d cycles with %0d packets seen",
                     cycle_count, seen_packets);
            $display("Test failed");
            $finish;
        end
        #5;
    endtask

    task automatic wait_request(input logic level);
        while (imem_req !== level) begin
            next_cycle();
        end
    endtask

    task automatic apply_redirect(input step_t s);
        if (s.redirect.trap || s.redirect.mispredict) begin
            wait_request(1'b1);
            redirect = s.redirect;
            model_pc = s.redirect.trap ? s.redirect.trap_pc : s.redirect.branch_pc;
            next_cycle();
            redirect = '0;
        end
    endtask

    // With imem_req low nothing can be consumed at the flush edge.
    task automatic apply_flush(input step_t s);
        if (s.flush) begin
            wait_request(1'b0);
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            check_packet(packet, bubble_packet(), "flush bubble");
        end
    endtask

    // Stall lands on a freshly loaded packet, so the hold is visible.
    // The next request goes up one cycle later and must stay up.
    task automatic apply_stall(input step_t s);
        fetch_packet_t held_packet;
        imem_req_t     held_addr;
        int            k;
        if (s.stall_cycles != 0) begin
            while (!(packet.valid || packet.exception)) begin
                next_cycle();
            end
            stall       = 1'b1;
            held_packet = packet;
            held_addr   = imem_addr;
            for (k = 0; k < s.stall_cycles; k++) begin
                next_cycle();
                check_packet(packet, held_packet, "packet under stall");
                check_addr(imem_addr, held_addr, "address under stall");
                if (imem_req !== 1'b1) begin
                    $display("FAIL t=%0t imem_req dropped while decode was stalled", $time);
                    ctrl_errors++;
                end
            end
            stall = 1'b0;
        end
    endtask

    task automatic collect_packets(input step_t s);
        int target;
        target = seen_packets + s.packets;
        while (seen_packets < target) begin
            next_cycle();
        end
    endtask

    task automatic load_tables();
        logic [31:0] base;
        base     = `RV32_RESET_VECTOR;
        prog[0]  = '{base,            32'h0010_0093, 1'b0};
        prog[1]  = '{base + 32'h04,   32'h0020_0113, 1'b0};
        prog[2]  = '{base + 32'h08,   32'h0000_0863, 1'b0};  // beq +16
        prog[3]  = '{base + 32'h0c,   32'h0200_006f, 1'b0};  // jal +32
        prog[4]  = '{base + 32'h28,   32'h0040_0213, 1'b0};
        prog[5]  = '{base + 32'h2c,   32'h0030_0193, 1'b0};
        prog[6]  = '{base + 32'h30,   32'hfe00_9ce3, 1'b0};  // bne -8
        prog[7]  = '{32'h0000_2000,   32'h0050_0293, 1'b1};
        prog[8]  = '{32'h0000_3000,   32'hff1f_f06f, 1'b0};  // jal -16
        prog[9]  = '{32'h0000_4000,   32'h0060_0313, 1'b0};
        prog[10] = '{32'h0000_5000,   32'h0070_0393, 1'b0};
        steps[0]  = make_step(0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3);
        steps[1]  = make_step(0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3);
        steps[2]  = make_step(0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 2);
        steps[3]  = make_step(3, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 2);
        steps[4]  = make_step(0, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0, 1);
        steps[5]  = make_step(0, 1'b0, 1'b0, 1'b1, 32'h0, 32'h3000, 2);
        steps[6]  = make_step(0, 1'b0, 1'b1, 1'b0, 32'h2000, 32'h0, 2);
        steps[7]  = make_step(0, 1'b0, 1'b1, 1'b1, 32'h4000, 32'h5000, 2);
        steps[8]  = make_step(2, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 2);
        steps[9]  = make_step(0, 1'b0, 1'b0, 1'b1, 32'h0, base, 3);
        steps[10] = make_step(2, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0, 2);
        steps[11] = make_step(0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3);
    endtask

    // Memory side of the four-phase bus, with a random ack delay per request.
    initial begin : memory_responder
        logic [31:0] word;
        logic        is_fault;
        int          delay_left;
        imem_ack   = 1'b0;
        imem_resp  = '0;
        lcg_state  = 32'hca87_5565;
        delay_left = 0;
        forever begin
            @(posedge clk);
            #5;
            if (imem_ack) begin
                if (!imem_req) begin
                    imem_ack   = 1'b0;
                    imem_resp  = '0;
                    lcg_state  = lcg_next(lcg_state);
                    delay_left = lcg_state[29:28];
                end
            end else if (imem_req) begin
                if (delay_left == 0) begin
                    lookup_program(imem_addr.addr, word, is_fault);
                    imem_resp.data  = word;
                    imem_resp.fault = is_fault;
                    imem_ack        = 1'b1;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    initial begin
        imem_req_t first_addr;
        int        s;
        reset         = 1'b1;
        stall         = 1'b0;
        flush         = 1'b0;
        redirect      = '0;
        stall_at_load = 1'b0;
        seen_packets  = 0;
        cycle_count   = 0;
        packet_errors = 0;
        addr_errors   = 0;
        ctrl_errors   = 0;
        model_pc      = `RV32_RESET_VECTOR;
        load_tables();
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        while (imem_req !== 1'b1) begin
            check_packet(packet, bubble_packet(), "packet before first fetch");
            next_cycle();
        end
        first_addr.addr = `RV32_RESET_VECTOR;
        check_addr(imem_addr, first_addr, "first fetch address");
        for (s = 0; s < NUM_STEPS; s++) begin
            apply_redirect(steps[s]);
            apply_flush(steps[s]);
            apply_stall(steps[s]);
            collect_packets(steps[s]);
        end
        $display("Errors: %0d packet, %0d address, %0d control, %0d packets checked",
                 packet_errors, addr_errors, ctrl_errors, seen_packets);
        if (packet_errors + addr_errors + ctrl_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rv32_front_top.sv ====
`timescale 1ns/1ps

module rv32_front_top
    import rv32_isa_pkg::*;
    import rv32_front_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  redirect_t     redirect,
    output logic          imem_req,
    output imem_req_t     imem_addr,
    input  logic          imem_ack,
    input  imem_resp_t    imem_resp,
    output fetch_packet_t packet
);
    logic        consume;
    logic        discard;
    logic        pc_hold;
    logic        redirect_pending;
    logic        pred_taken;
    logic [31:0] pred_offset;
    imem_req_t   pc;
    rv32_instr_u fetched_word;

    // The pc register drives the bus directly.
    assign imem_addr = pc;

    assign fetched_word = imem_resp.data;

    rv32_fetch_seq u_fetch_seq (
        .clk              (clk),
        .reset            (reset),
        .imem_ack         (imem_ack),
        .stall            (stall),
        .redirect_pending (redirect_pending),
        .imem_req         (imem_req),
        .consume          (consume),
        .discard          (discard),
        .pc_hold          (pc_hold)
    );

    rv32_pc_gen u_pc_gen (
        .clk              (clk),
        .reset            (reset),
        .pc_hold          (pc_hold),
        .consume          (consume),
        .discard          (discard),
        .redirect         (redirect),
        .pred_offset      (pred_offset),
        .pc               (pc),
        .redirect_pending (redirect_pending)
    );

    rv32_branch_predict u_branch_predict (
        .word        (fetched_word),
        .pred_taken  (pred_taken),
        .pred_offset (pred_offset)
    );

    rv32_fetch_out u_fetch_out (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .consume    (consume),
        .pc         (pc),
        .resp       (imem_resp),
        .pred_taken (pred_taken),
        .packet     (packet)
    );

endmodule

// ==== rv32_fetch_out.sv ====
`timescale 1ns/1ps

`include "rv32_front_cfg.svh"

module rv32_fetch_out
    import rv32_front_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  logic          consume,
    input  imem_req_t     pc,
    input  imem_resp_t    resp,
    input  logic          pred_taken,
    output fetch_packet_t packet
);
    fetch_packet_t bubble;

    assign bubble = '{
        valid:           1'b0,
        exception:       1'b0,
        cause:           '0,
        predicted_taken: 1'b0,
        pc:              32'd0,
        instr:           `RV32_INSTR_NOP
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            packet <= bubble;
        end else if (!stall) begin
            if (flush) begin
                packet <= bubble;
            end else if (consume && resp.fault) begin
                packet.valid           <= 1'b0;
                packet.exception       <= 1'b1;
                packet.cause           <= `RV32_MCAUSE_INSTR_FAULT;
                packet.predicted_taken <= 1'b0;
                packet.pc              <= pc.addr;
                packet.instr           <= `RV32_INSTR_NOP;
            end else if (consume) begin
                packet.valid           <= 1'b1;
                packet.exception       <= 1'b0;
                packet.cause           <= '0;
                packet.predicted_taken <= pred_taken;
                packet.pc              <= pc.addr;
                packet.instr           <= resp.data;
            end else begin
                // Nothing new this cycle, so decode must not see the old
                // instruction or fault a second time.
                packet.valid     <= 1'b0;
                packet.exception <= 1'b0;
            end
        end
    end

    // A response taken while decode is stalled would never reach the packet.
    assert property (@(posedge clk) disable iff (reset)
        consume |-> !stall)
        else $error("response consumed while decode was stalled");

endmodule

// ==== rv32_branch_predict.sv ====
`timescale 1ns/1ps

module rv32_branch_predict
    import rv32_isa_pkg::*;
(
    input  rv32_instr_u word,
    output logic        pred_taken,
    output logic [31:0] pred_offset
);
    logic [31:0] imm_j;
    logic [31:0] imm_b;

    assign imm_j = {{12{word.j.imm20}}, word.j.imm19_12, word.j.imm11,
                    word.j.imm10_1, 1'b0};

    assign imm_b = {{20{word.b.imm12}}, word.b.imm11, word.b.imm10_5,
                    word.b.imm4_1, 1'b0};

    // Static rule: jumps always go, loops (negative offsets) are
    // assumed to iterate, forward branches fall through.
    always_comb begin
        pred_taken  = 1'b0;
        pred_offset = 32'd4;
        case (word.j.opcode)
            OPC_JAL: begin
                pred_taken  = 1'b1;
                pred_offset = imm_j;
            end
            OPC_BRANCH: begin
                if (word.b.imm12) begin
                    pred_taken  = 1'b1;
                    pred_offset = imm_b;
                end
            end
            default: begin
                pred_taken  = 1'b0;
                pred_offset = 32'd4;
            end
        endcase
    end

endmodule

// ==== rv32_pc_gen.sv ====
`timescale 1ns/1ps

`include "rv32_front_cfg.svh"

module rv32_pc_gen
    import rv32_front_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pc_hold,
    input  logic        consume,
    input  logic        discard,
    input  redirect_t   redirect,
    input  logic [31:0] pred_offset,
    output imem_req_t   pc,
    output logic        redirect_pending
);
    logic        held_valid;
    logic [31:0] held_pc;
    logic        live_redirect;
    logic [31:0] next_pc;

    assign live_redirect = redirect.trap || redirect.mispredict;

    // A live pulse counts as pending too, so a response that arrives in
    // the same cycle as the redirect is dropped as well.
    assign redirect_pending = held_valid || live_redirect;

    always_comb begin
        if (held_valid) begin
            next_pc = held_pc;
        end else if (redirect.trap) begin
            next_pc = redirect.trap_pc;
        end else if (redirect.mispredict) begin
            next_pc = redirect.branch_pc;
        end else begin
            next_pc = pc.addr + pred_offset;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc.addr    <= `RV32_RESET_VECTOR;
            held_valid <= 1'b0;
        end else if (consume || discard) begin
            pc.addr    <= next_pc;
            held_valid <= 1'b0;
        end else if (pc_hold && !held_valid && live_redirect) begin
            // Only the first redirect while frozen is kept.
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_hold && !held_valid && live_redirect) begin
            held_pc <= redirect.trap ? redirect.trap_pc : redirect.branch_pc;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        pc.addr[1:0] == 2'b00)
        else $error("fetch address 0x%08h is not word aligned", pc.addr);

endmodule

// ==== rv32_fetch_seq.sv ====
`timescale 1ns/1ps

module rv32_fetch_seq (
    input  logic clk,
    input  logic reset,
    input  logic imem_ack,
    input  logic stall,
    input  logic redirect_pending,
    output logic imem_req,
    output logic consume,
    output logic discard,
    output logic pc_hold
);
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        DRAIN
    } state_t;

    state_t state;
    state_t state_next;
    logic   ack_in_req;

    // The request is a pure state decode, so the address and request
    // stay stable for as long as the sequencer sits in REQ.
    assign imem_req = (state == REQ);

    assign ack_in_req = imem_req && imem_ack;

    // A response fetched from an address made stale by a redirect is
    // dropped at once. It never reaches decode, so stall does not matter.
    assign discard = ack_in_req && redirect_pending;

    // A good response is taken only when decode can accept the packet.
    // Otherwise the request stays up and the memory keeps holding ack.
    assign consume = ack_in_req && !redirect_pending && !stall;

    // The pc moves only on the edge where a response is taken or dropped.
    assign pc_hold = !(consume || discard);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (!imem_ack) begin
                    state_next = REQ;
                end
            end
            REQ: begin
                if (consume) begin
                    state_next = WAIT_ACK_LOW;
                end else if (discard) begin
                    state_next = DRAIN;
                end
            end
            WAIT_ACK_LOW: begin
                if (!imem_ack) begin
                    state_next = REQ;
                end
            end
            DRAIN: begin
                // Stale response dropped; the pc already holds the redirect target.
                if (!imem_ack) begin
                    state_next = REQ;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // The memory answers only a request that is up.
    assert property (@(posedge clk) disable iff (reset)
        $rose(imem_ack) |-> imem_req)
        else $error("imem_ack raised with no request pending");

    // The memory keeps ack up until the request has dropped.
    assert property (@(posedge clk) disable iff (reset)
        $fell(imem_ack) |-> !imem_req)
        else $error("imem_ack dropped while imem_req was still high");

endmodule

// ==== rv32_front_pkg.sv ====
package rv32_front_pkg;

    // Instruction bus request, the fetch address.
    typedef struct packed {
        logic [31:0] addr;
    } imem_req_t;

    // Instruction bus response, valid while imem_ack is high.
    typedef struct packed {
        logic [31:0] data;
        logic        fault;
    } imem_resp_t;

    // Redirect from a later stage. Both flags are single-cycle pulses.
    typedef struct packed {
        logic        trap;
        logic        mispredict;
        logic [31:0] trap_pc;
        logic [31:0] branch_pc;
    } redirect_t;

    // Registered packet handed to decode.
    typedef struct packed {
        logic        valid;
        logic        exception;
        logic [3:0]  cause;
        logic        predicted_taken;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_packet_t;

endpackage

// ==== rv32_isa_pkg.sv ====
package rv32_isa_pkg;

    // Major opcodes of the RV32I base set.
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } rv32_opcode_e;

    // J-type layout, used by JAL.
    typedef struct packed {
        logic         imm20;
        logic [9:0]   imm10_1;
        logic         imm11;
        logic [7:0]   imm19_12;
        logic [4:0]   rd;
        rv32_opcode_e opcode;
    } rv32_j_fields_t;

    // B-type layout, used by the conditional branches.
    typedef struct packed {
        logic         imm12;
        logic [5:0]   imm10_5;
        logic [4:0]   rs2;
        logic [4:0]   rs1;
        logic [2:0]   funct3;
        logic [3:0]   imm4_1;
        logic         imm11;
        rv32_opcode_e opcode;
    } rv32_b_fields_t;

    // One fetched word, seen raw or through either immediate layout.
    typedef union packed {
        logic [31:0]    raw;
        rv32_j_fields_t j;
        rv32_b_fields_t b;
    } rv32_instr_u;

endpackage

// ==== rv32_front_cfg.svh ====
`ifndef RV32_FRONT_CFG_SVH
`define RV32_FRONT_CFG_SVH

// Address of the first instruction fetched after reset.
// Any word-aligned value works.
`define RV32_RESET_VECTOR 32'h0000_1000

// addi x0, x0, 0
`define RV32_INSTR_NOP 32'h0000_0013

// Exception code reported for a failed instruction fetch.
`define RV32_MCAUSE_INSTR_FAULT 4'd1

// Width of the cause field carried in the fetch packet.
`define RV32_CAUSE_W 4

`endif
